/* logic/sdram_bus_pkg.sv */
// SDRAM controller port: 16-bit writes with active-low byte mask, 32-bit read word, no bursts

package sdram_bus_pkg;

    localparam int sdram_aw = 22;   // word address width

    // command towards the controller
    // rd/wr are held until ack, payload is stable meanwhile
    typedef struct packed {
        logic                rd;
        logic                wr;
        logic [sdram_aw-1:0] addr;
        logic [15:0]         wdata;
        logic [1:0]          wrmask;  // active low, bit 1 = upper byte
    } sdram_cmd_t;

    // answer from the controller
    // one rdy follows every ack, reads and writes alike
    typedef struct packed {
        logic        ack;    // command taken
        logic        rdy;    // data ready
        logic [31:0] rdata;  // must hold one cycle past rdy
    } sdram_rsp_t;

endpackage

/* logic/slot_pkg.sv */
// client slot definitions: two fixed 8-bit slots, word offsets sized to the SDRAM address bus

package slot_pkg;

    localparam int slot0_aw = 12;  // work RAM, byte address
    localparam int slot1_aw = 16;  // ROM, byte address
    localparam int slot_dw  = 8;

    // SDRAM word bases
    localparam logic [sdram_bus_pkg::sdram_aw-1:0] slot0_offset = 22'h10000;
    localparam logic [sdram_bus_pkg::sdram_aw-1:0] slot1_offset = 22'h00000;

    typedef enum logic {
        op_read,
        op_write
    } slot_op_e;

    // requester to arbiter, valid held until the slot's done pulse
    typedef struct packed {
        logic                                 valid;
        slot_op_e                             op;
        logic [sdram_bus_pkg::sdram_aw-1:0]   addr;    // already offset
        logic [15:0]                          wdata;   // byte repeated twice
        logic [1:0]                           wrmask;  // active low
    } slot_req_t;

    typedef enum logic {
        arb_idle,
        arb_busy
    } arb_state_e;

endpackage

/* logic/slot_ram_rq.sv */
// slot 0 requester: client must hold cs, addr, wen and din until ok, one access in flight at a time
`timescale 1ns/1ps

module slot_ram_rq (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cs,
    input  logic                          wen,
    input  logic [slot_pkg::slot0_aw-1:0] addr,
    input  logic [slot_pkg::slot_dw-1:0]  din,
    output slot_pkg::slot_req_t           req,
    input  logic                          done,
    input  logic [31:0]                   rdata,
    output logic [slot_pkg::slot_dw-1:0]  dout,
    output logic                          ok
);
    import slot_pkg::*;

    logic                cs_q;
    logic [slot0_aw-1:0] addr_q;
    logic                wen_q;
    logic [slot_dw-1:0]  din_q;
    logic                byte_sel;  // addr bit 0 of the pending access
    logic                new_acc;

    // a rising cs, a new address or a flip of wen starts over
    // for writes a new data byte counts as well
    assign new_acc = cs && (!cs_q || addr != addr_q || wen != wen_q ||
                            (wen && din != din_q));

    always_ff @(posedge clk) begin
        addr_q <= addr;
        wen_q  <= wen;
        din_q  <= din;
        if (rst) begin
            cs_q      <= 1'b0;
            req.valid <= 1'b0;
            ok        <= 1'b0;
        end else begin
            cs_q <= cs;
            if (new_acc) begin
                req.valid <= 1'b1;
                ok        <= 1'b0;
            end else if (done) begin
                req.valid <= 1'b0;
                ok        <= cs;  // client may have walked away
            end else if (!cs) begin
                ok <= 1'b0;
            end
        end
    end

    // request payload, no reset needed
    always_ff @(posedge clk) begin
        if (new_acc) begin
            req.op     <= wen ? op_write : op_read;
            req.addr   <= slot0_offset + sdram_bus_pkg::sdram_aw'(addr[slot0_aw-1:1]);
            req.wdata  <= {din, din};
            req.wrmask <= addr[0] ? 2'b01 : 2'b10;
            byte_sel   <= addr[0];
        end
    end

    always_ff @(posedge clk) begin
        if (done && req.op == op_read) begin
            dout <= byte_sel ? rdata[15:8] : rdata[7:0];
        end
    end

endmodule

/* logic/slot_rom_rq.sv */
// read-only slot 1 requester with a one-word cache and no flush, cs and addr held until ok
`timescale 1ns/1ps

module slot_rom_rq (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cs,
    input  logic [slot_pkg::slot1_aw-1:0] addr,
    output slot_pkg::slot_req_t           req,
    input  logic                          done,
    input  logic [31:0]                   rdata,
    output logic [slot_pkg::slot_dw-1:0]  dout,
    output logic                          ok
);
    import slot_pkg::*;

    logic                                 cs_q;
    logic [slot1_aw-1:0]                  addr_q;
    logic [sdram_bus_pkg::sdram_aw-1:0]   word_addr;
    logic [sdram_bus_pkg::sdram_aw-1:0]   cache_addr;
    logic [15:0]                          cache_data;
    logic                                 cache_valid;
    logic                                 byte_sel;
    logic                                 new_acc;
    logic                                 hit;
    logic                                 req_valid;
    logic [sdram_bus_pkg::sdram_aw-1:0]   req_addr;

    assign word_addr = slot1_offset + sdram_bus_pkg::sdram_aw'(addr[slot1_aw-1:1]);
    assign new_acc   = cs && (!cs_q || addr != addr_q);
    assign hit       = cache_valid && word_addr == cache_addr;

    always_ff @(posedge clk) begin
        addr_q <= addr;
        if (rst) begin
            cs_q        <= 1'b0;
            req_valid   <= 1'b0;
            ok          <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            cs_q <= cs;
            if (new_acc) begin
                req_valid <= !hit;  // a hit is answered locally
                ok        <= hit;
            end else if (done) begin
                req_valid   <= 1'b0;
                ok          <= cs;
                cache_valid <= 1'b1;
            end else if (!cs) begin
                ok <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_acc) begin
            req_addr <= word_addr;
            byte_sel <= addr[0];
            if (hit) dout <= addr[0] ? cache_data[15:8] : cache_data[7:0];
        end else if (done) begin
            cache_addr <= req_addr;
            cache_data <= rdata[15:0];
            dout       <= byte_sel ? rdata[15:8] : rdata[7:0];
        end
    end

    // read only slot
    always_comb begin
        req.valid  = req_valid;
        req.op     = op_read;
        req.addr   = req_addr;
        req.wdata  = 16'h0000;
        req.wrmask = 2'b11;
    end

endmodule

/* logic/slot_arbiter.sv */
// fixed-priority arbiter, slot 0 first, one command in flight until its done strobe
`timescale 1ns/1ps

module slot_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  slot_pkg::slot_req_t       req0,
    input  slot_pkg::slot_req_t       req1,
    input  logic [1:0]                done,
    output sdram_bus_pkg::sdram_cmd_t cmd,
    output logic [1:0]                grant
);
    import slot_pkg::*;

    arb_state_e state;
    slot_req_t  win;
    logic [1:0] pick;

    // slot 0 always wins a tie
    assign win  = req0.valid ? req0 : req1;
    assign pick = req0.valid ? 2'b01 : (req1.valid ? 2'b10 : 2'b00);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= arb_idle;
            grant  <= 2'b00;
            cmd.rd <= 1'b0;
            cmd.wr <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (win.valid) begin
                        state  <= arb_busy;
                        grant  <= pick;
                        cmd.rd <= win.op == op_read;
                        cmd.wr <= win.op == op_write;
                    end
                end
                arb_busy: begin
                    // cmd stays put while the port waits for ack and rdy
                    if (|(done & grant)) begin
                        state  <= arb_idle;
                        grant  <= 2'b00;
                        cmd.rd <= 1'b0;
                        cmd.wr <= 1'b0;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // payload latched only when a slot is taken
    always_ff @(posedge clk) begin
        if (state == arb_idle && win.valid) begin
            cmd.addr   <= win.addr;
            cmd.wdata  <= win.wdata;
            cmd.wrmask <= win.op == op_write ? win.wrmask : 2'b11;
        end
    end

endmodule

/* logic/sdram_cmd_port.sv */
// command port: drops rd/wr after ack, done comes one cycle after rdy; rdy never shares a cycle with ack
`timescale 1ns/1ps

module sdram_cmd_port (
    input  logic                      clk,
    input  logic                      rst,
    input  sdram_bus_pkg::sdram_cmd_t cmd_in,
    input  logic [1:0]                grant,
    input  sdram_bus_pkg::sdram_rsp_t rsp,
    output sdram_bus_pkg::sdram_cmd_t cmd,
    output logic [1:0]                done
);
    import sdram_bus_pkg::*;

    logic acked;     // controller took the current command
    logic wait_data; // between ack and rdy
    logic take;

    assign take = rsp.ack && (cmd.rd || cmd.wr);

    // strobes masked once taken, payload straight through
    always_comb begin
        cmd    = cmd_in;
        cmd.rd = cmd_in.rd && !acked;
        cmd.wr = cmd_in.wr && !acked;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acked     <= 1'b0;
            wait_data <= 1'b0;
            done      <= 2'b00;
        end else begin
            done <= (rsp.rdy && wait_data) ? grant : 2'b00;
            if (take) begin
                acked     <= 1'b1;
                wait_data <= 1'b1;
            end else if (rsp.rdy) begin
                wait_data <= 1'b0;
            end
            if (|done) acked <= 1'b0;  // arbiter drops rd/wr on the same edge
        end
    end

endmodule

/* logic/sdram_2slot_mux.sv */
// two-slot SDRAM mux top: slot 0 read/write work RAM, slot 1 cached ROM, no refresh or bursts
`timescale 1ns/1ps

module sdram_2slot_mux (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          slot0_cs,
    input  logic                          slot0_wen,
    input  logic [slot_pkg::slot0_aw-1:0] slot0_addr,
    input  logic [slot_pkg::slot_dw-1:0]  slot0_din,
    output logic [slot_pkg::slot_dw-1:0]  slot0_dout,
    output logic                          slot0_ok,
    input  logic                          slot1_cs,
    input  logic [slot_pkg::slot1_aw-1:0] slot1_addr,
    output logic [slot_pkg::slot_dw-1:0]  slot1_dout,
    output logic                          slot1_ok,
    output sdram_bus_pkg::sdram_cmd_t     sdram_cmd,
    input  sdram_bus_pkg::sdram_rsp_t     sdram_rsp
);
    import slot_pkg::*;
    import sdram_bus_pkg::*;

    slot_req_t  req0;
    slot_req_t  req1;
    sdram_cmd_t arb_cmd;
    logic [1:0] grant;
    logic [1:0] done;

    slot_ram_rq slot0_rq_i (
        .clk   (clk),
        .rst   (rst),
        .cs    (slot0_cs),
        .wen   (slot0_wen),
        .addr  (slot0_addr),
        .din   (slot0_din),
        .req   (req0),
        .done  (done[0]),
        .rdata (sdram_rsp.rdata),
        .dout  (slot0_dout),
        .ok    (slot0_ok)
    );

    slot_rom_rq slot1_rq_i (
        .clk   (clk),
        .rst   (rst),
        .cs    (slot1_cs),
        .addr  (slot1_addr),
        .req   (req1),
        .done  (done[1]),
        .rdata (sdram_rsp.rdata),
        .dout  (slot1_dout),
        .ok    (slot1_ok)
    );

    slot_arbiter slot_arbiter_i (
        .clk   (clk),
        .rst   (rst),
        .req0  (req0),
        .req1  (req1),
        .done  (done),
        .cmd   (arb_cmd),
        .grant (grant)
    );

    sdram_cmd_port sdram_cmd_port_i (
        .clk    (clk),
        .rst    (rst),
        .cmd_in (arb_cmd),
        .grant  (grant),
        .rsp    (sdram_rsp),
        .cmd    (sdram_cmd),
        .done   (done)
    );

endmodule

/* dv/tb_clock.sv */
// clock and reset source for the testbench: 4 ns period, reset high from time zero for 10 cycles
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);
    localparam int half_period  = 2;   // ns
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;  // released on a rising edge like every other input
    end

endmodule

/* dv/sdram_2slot_tb.sv */
// testbench for sdram_2slot_mux: model covers SDRAM words 0 to 0x1ffff, random ack/rdy delays from seed 8
`timescale 1ns/1ps

module sdram_2slot_tb;
    import slot_pkg::*;
    import sdram_bus_pkg::*;

    localparam int max_lines       = 64;
    localparam int cycles_per_line = 60;
    localparam int mem_words       = 1 << 17;
    localparam int m_idle          = 0;
    localparam int m_ack           = 1;
    localparam int m_rdy           = 2;

    logic                clk;
    logic                rst;
    logic                slot0_cs;
    logic                slot0_wen;
    logic [slot0_aw-1:0] slot0_addr;
    logic [slot_dw-1:0]  slot0_din;
    logic [slot_dw-1:0]  slot0_dout;
    logic                slot0_ok;
    logic                slot1_cs;
    logic [slot1_aw-1:0] slot1_addr;
    logic [slot_dw-1:0]  slot1_dout;
    logic                slot1_ok;
    sdram_cmd_t          sdram_cmd;
    sdram_rsp_t          sdram_rsp;

    logic [15:0] stim [0:5*max_lines-1];  // five columns per line
    logic [15:0] mem [0:mem_words-1];
    int          n_lines;
    int          line;
    int          i;
    int unsigned seed;
    int          errors      = 0;
    int          checks      = 0;
    int          tests       = 0;
    int          cycles      = 0;
    int          cycle_limit = 0;
    int          cmd_count   = 0;
    int          rdy_count   = 0;

    // controller model
    int          m_state = m_idle;
    int          m_cnt;
    int          ack_delay;
    sdram_cmd_t  m_cmd;
    logic [16:0] m_idx;

    logic pend0 = 1'b0;  // access in flight, per slot
    logic pend1 = 1'b0;
    logic ok0_q = 1'b0;
    logic ok1_q = 1'b0;

    tb_clock tb_clock_i (
        .clk (clk),
        .rst (rst)
    );

    sdram_2slot_mux sdram_2slot_mux_i (
        .clk        (clk),
        .rst        (rst),
        .slot0_cs   (slot0_cs),
        .slot0_wen  (slot0_wen),
        .slot0_addr (slot0_addr),
        .slot0_din  (slot0_din),
        .slot0_dout (slot0_dout),
        .slot0_ok   (slot0_ok),
        .slot1_cs   (slot1_cs),
        .slot1_addr (slot1_addr),
        .slot1_dout (slot1_dout),
        .slot1_ok   (slot1_ok),
        .sdram_cmd  (sdram_cmd),
        .sdram_rsp  (sdram_rsp)
    );

    // power-up content, upper address bits folded in so the two slot regions differ
    function automatic logic [15:0] fill_word(input logic [21:0] a);
        return a[15:0] ^ 16'h5a5a ^ {a[21:16], 10'h000};
    endfunction

    function automatic string op_name(input logic [15:0] op);
        case (op)
            16'd0:   return "read";
            16'd1:   return "write";
            16'd2:   return "cached read";
            default: return "paired read";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    // SDRAM controller stand-in, one command at a time
    always @(posedge clk) begin
        if (rst) begin
            sdram_rsp.ack <= 1'b0;
            sdram_rsp.rdy <= 1'b0;
            m_state       <= m_idle;
        end else begin
            sdram_rsp.ack <= 1'b0;
            sdram_rsp.rdy <= 1'b0;
            case (m_state)
                m_idle: begin
                    if (sdram_cmd.rd || sdram_cmd.wr) begin
                        m_cmd     <= sdram_cmd;
                        cmd_count <= cmd_count + 1;
                        ack_delay = $urandom % 4;
                        if (ack_delay == 0) begin
                            sdram_rsp.ack <= 1'b1;
                            m_cnt         <= $urandom % 4;  // rdy 1 to 4 cycles later
                            m_state       <= m_rdy;
                        end else begin
                            m_cnt   <= ack_delay - 1;
                            m_state <= m_ack;
                        end
                    end
                end
                m_ack: begin
                    if (sdram_cmd !== m_cmd) begin
                        $display("command changed at %0t while waiting for ack", $time);
                        errors = errors + 1;
                    end
                    if (m_cnt == 0) begin
                        sdram_rsp.ack <= 1'b1;
                        m_cnt         <= $urandom % 4;
                        m_state       <= m_rdy;
                    end else begin
                        m_cnt <= m_cnt - 1;
                    end
                end
                default: begin
                    if (m_cnt == 0) begin
                        m_idx = m_cmd.addr[16:0];
                        if (m_cmd.addr[21:17] != 5'd0) begin
                            $display("command address 0x%0h is outside the modeled SDRAM",
                                     m_cmd.addr);
                            errors = errors + 1;
                        end else if (m_cmd.wr) begin
                            if (!m_cmd.wrmask[0]) mem[m_idx][7:0] <= m_cmd.wdata[7:0];
                            if (!m_cmd.wrmask[1]) mem[m_idx][15:8] <= m_cmd.wdata[15:8];
                        end
                        sdram_rsp.rdata <= {mem[m_idx + 17'd1], mem[m_idx]};  // held until next rdy
                        sdram_rsp.rdy   <= 1'b1;
                        rdy_count       <= rdy_count + 1;
                        m_state         <= m_idle;
                    end else begin
                        m_cnt <= m_cnt - 1;
                    end
                end
            endcase
        end
    end

    // an ok edge with nothing in flight is a reply without an access
    always @(posedge clk) begin
        if (!rst && slot0_ok && !ok0_q && !pend0) begin
            $display("slot 0 ok rose at %0t with no access in flight", $time);
            errors = errors + 1;
        end
        if (!rst && slot1_ok && !ok1_q && !pend1) begin
            $display("slot 1 ok rose at %0t with no access in flight", $time);
            errors = errors + 1;
        end
        ok0_q <= slot0_ok;
        ok1_q <= slot1_ok;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic run_single(input int ln);
        logic [15:0] slot;
        logic [15:0] op;
        logic [15:0] addr;
        logic [15:0] wdata;
        logic [15:0] exp_byte;
        logic [7:0]  dout;
        int          cmds_before;
        int          rdys_before;
        int          errs_before;
        int          delta;
        slot        = stim[5*ln];
        op          = stim[5*ln+1];
        addr        = stim[5*ln+2];
        wdata       = stim[5*ln+3];
        exp_byte    = stim[5*ln+4];
        cmds_before = cmd_count;
        rdys_before = rdy_count;
        errs_before = errors;
        delta       = (op == 16'd2) ? 0 : 1;  // a cache hit issues nothing
        if (slot == 16'd0) begin
            slot0_cs   <= 1'b1;
            slot0_wen  <= op == 16'd1;
            slot0_addr <= addr[slot0_aw-1:0];
            slot0_din  <= wdata[7:0];
            pend0 = 1'b1;
            @(posedge clk);
            while (!slot0_ok) @(posedge clk);
            dout = slot0_dout;
            slot0_cs <= 1'b0;
        end else begin
            if (op == 16'd1) begin
                $display("stimulus line %0d asks for a write on read-only slot 1", ln);
                errors = errors + 1;
            end
            slot1_cs   <= 1'b1;
            slot1_addr <= addr[slot1_aw-1:0];
            pend1 = 1'b1;
            @(posedge clk);
            while (!slot1_ok) @(posedge clk);
            dout = slot1_dout;
            slot1_cs <= 1'b0;
        end
        if (op != 16'd1) begin
            check_value(slot == 16'd0 ? "slot0_dout" : "slot1_dout", dout, exp_byte);
        end
        check_value("sdram command count", cmd_count - cmds_before, delta);
        check_value("sdram rdy count", rdy_count - rdys_before, delta);
        @(posedge clk);  // gap, ok drops before the next access
        pend0 = 1'b0;
        pend1 = 1'b0;
        tests = tests + 1;
        $display("test %0d: slot %0d %s at 0x%0h %s", tests, slot, op_name(op), addr,
                 errors == errs_before ? "passed" : "failed");
    endtask

    // slot 0 line plus the following slot 1 line, cs raised together
    task automatic run_pair(input int ln);
        logic [15:0] addr0;
        logic [15:0] exp0;
        logic [15:0] addr1;
        logic [15:0] exp1;
        int          cmds_before;
        int          rdys_before;
        int          errs_before;
        int          n;
        int          t0;
        int          t1;
        addr0       = stim[5*ln+2];
        exp0        = stim[5*ln+4];
        addr1       = stim[5*ln+7];
        exp1        = stim[5*ln+9];
        cmds_before = cmd_count;
        rdys_before = rdy_count;
        errs_before = errors;
        if (stim[5*ln] != 16'd0 || stim[5*ln+5] != 16'd1 || stim[5*ln+6] != 16'd0) begin
            $display("stimulus line %0d: a paired read needs slot 0 then a slot 1 read", ln);
            errors = errors + 1;
        end
        slot0_cs   <= 1'b1;
        slot0_wen  <= 1'b0;
        slot0_addr <= addr0[slot0_aw-1:0];
        slot1_cs   <= 1'b1;
        slot1_addr <= addr1[slot1_aw-1:0];
        pend0 = 1'b1;
        pend1 = 1'b1;
        n  = 0;
        t0 = -1;
        t1 = -1;
        while (t0 < 0 || t1 < 0) begin
            @(posedge clk);
            n = n + 1;
            if (slot0_ok && t0 < 0) t0 = n;
            if (slot1_ok && t1 < 0) t1 = n;
        end
        slot0_cs <= 1'b0;
        slot1_cs <= 1'b0;
        check_value("slot0_dout", slot0_dout, exp0);
        check_value("slot1_dout", slot1_dout, exp1);
        check_value("slot0_ok before slot1_ok", t0 < t1, 1);
        check_value("sdram command count", cmd_count - cmds_before, 2);
        check_value("sdram rdy count", rdy_count - rdys_before, 2);
        @(posedge clk);
        pend0 = 1'b0;
        pend1 = 1'b0;
        tests = tests + 1;
        $display("test %0d: paired read at 0x%0h and 0x%0h %s", tests, addr0, addr1,
                 errors == errs_before ? "passed" : "failed");
    endtask

    initial begin
        seed       = $urandom(8);
        slot0_cs   = 1'b0;
        slot0_wen  = 1'b0;
        slot0_addr = '0;
        slot0_din  = '0;
        slot1_cs   = 1'b0;
        slot1_addr = '0;
        sdram_rsp  = '0;
        for (i = 0; i < 5*max_lines; i = i + 1) stim[i] = 16'hffff;  // end marker
        for (i = 0; i < mem_words; i = i + 1) mem[i] = fill_word(i[21:0]);
        $readmemh("dv/sdram_2slot_stimulus.txt", stim);
        n_lines = 0;
        while (n_lines < max_lines && stim[5*n_lines] != 16'hffff) n_lines = n_lines + 1;
        if (n_lines == 0) begin
            $display("no stimulus lines found in dv/sdram_2slot_stimulus.txt");
            errors = errors + 1;
        end
        cycle_limit = n_lines * cycles_per_line;
        wait (rst == 1'b0);
        @(posedge clk);
        line = 0;
        while (line < n_lines) begin
            if (stim[5*line+1] == 16'd3) begin
                run_pair(line);
                line = line + 2;
            end else begin
                run_single(line);
                line = line + 1;
            end
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* dv/sdram_2slot_stimulus.txt */
// columns, all hex: slot op byte_addr write_data expected_read_byte
// op 0 read, 1 write, 2 read served by the ROM cache, 3 slot 0 read paired with the next line
0001 0000 0000 0000 005a
0001 0000 1235 0000 0053
0001 0000 7ffe 0000 00a5
0001 0000 4c81 0000 007c
0001 0002 4c81 0000 007c
0001 0002 4c80 0000 001a
0000 0000 0100 0000 00da
0000 0001 0100 003c 0000
0000 0000 0100 0000 003c
0000 0000 0101 0000 005e
0000 0001 00a7 00c3 0000
0000 0000 00a7 0000 00c3
0000 0000 00a6 0000 0009
0000 0003 00a7 0000 00c3
0001 0000 0002 0000 005b
0000 0003 0fff 0000 0059
0001 0000 abcd 0000 000f
0001 0002 abcd 0000 000f
0000 0001 0fff 0011 0000
0000 0000 0fff 0000 0011
0000 0000 0ffe 0000 00a5
0001 0000 4c81 0000 007c

/* sim.f */
logic/sdram_bus_pkg.sv
logic/slot_pkg.sv
logic/slot_ram_rq.sv
logic/slot_rom_rq.sv
logic/slot_arbiter.sv
logic/sdram_cmd_port.sv
logic/sdram_2slot_mux.sv
dv/tb_clock.sv
dv/sdram_2slot_tb.sv
